// File: hw/umi_macros.svh
//##########################################################################
// UMI memory endpoint global parameters
// Packet widths and local memory depth for the whole design
//##########################################################################
`ifndef UMI_MACROS_SVH
`define UMI_MACROS_SVH

// Address width, both dst and src
`define UMI_AW 32

// Data and payload width
`define UMI_DW 32

// Local memory depth in words
// Word index comes from address bits above the byte offset
`define UMI_MEM_WORDS 256

`endif

// File: hw/umi_pkg.sv
//##########################################################################
// UMI packet definitions
// Opcode encoding, command word layout and full packet layout
//##########################################################################
`include "umi_macros.svh"

package umi_pkg;

   // Supported opcodes, anything else is unknown
   typedef enum logic [7:0]
   {
      UMI_READ      = 8'h01,           // Request read
      UMI_RESP_READ = 8'h02,           // Read response
      UMI_WRITE     = 8'h03            // Request write, posted
   } umi_opcode_e;

   // Command word, 32 bits
   typedef struct packed
   {
      logic [19:0] options;            // Bits 31:12, passed through
      logic [3:0]  size;               // Bits 11:8, log2 of bytes
      umi_opcode_e opcode;             // Bits 7:0
   } umi_cmd_t;

   // Full packet as seen on device ports
   // cmd sits in the top 32 bits, payload at the bottom
   typedef struct packed
   {
      umi_cmd_t              cmd;      // Command word
      logic [`UMI_AW-1:0]    dst_addr; // Target address
      logic [`UMI_AW-1:0]    src_addr; // Return address
      logic [`UMI_DW-1:0]    payload;  // Write data or read data
   } umi_packet_t;

endpackage

// File: hw/mem_pkg.sv
//##########################################################################
// Local memory access definitions
// Request and response between endpoint and word memory
//##########################################################################
`include "umi_macros.svh"

package mem_pkg;

   // Single-cycle memory request, no handshake
   typedef struct packed
   {
      logic [`UMI_AW-1:0] addr;        // Byte address
      logic               write;       // Write strobe
      logic               read;        // Read strobe
      logic [3:0]         size;        // log2 of bytes written
      logic [`UMI_DW-1:0] wrdata;      // Write data, lane aligned
   } mem_req_t;

   // Same-cycle read return
   typedef struct packed
   {
      logic [`UMI_DW-1:0] rddata;      // Whole addressed word
   } mem_rsp_t;

endpackage

// File: hw/umi_unpack.sv
//##########################################################################
// UMI request unpack
// Splits an incoming packet into command fields, addresses and data
//##########################################################################
`include "umi_macros.svh"

module umi_unpack
  (
   // Incoming packet
   input  umi_pkg::umi_packet_t  packet,
   // Command fields
   output umi_pkg::umi_opcode_e  opcode,
   output logic [3:0]            size,
   output logic [19:0]           options,
   // Addresses
   output logic [`UMI_AW-1:0]    dst_addr,
   output logic [`UMI_AW-1:0]    src_addr,
   // Write data
   output logic [`UMI_DW-1:0]    wrdata
   );

   import umi_pkg::*;

   umi_cmd_t cmd;                      // Command word view

   //#######################################################################
   // Command word
   //#######################################################################

   // Only place the request-side command layout gets interpreted
   assign cmd     = packet.cmd;

   assign opcode  = cmd.opcode;        // Bits 7:0
   assign size    = cmd.size;          // Bits 11:8
   assign options = cmd.options;       // Bits 31:12

   //#######################################################################
   // Addresses and payload
   //#######################################################################

   assign dst_addr = packet.dst_addr;  // Local target
   assign src_addr = packet.src_addr;  // Where a response goes back to

   // Payload only meaningful for writes
   assign wrdata   = packet.payload;

endmodule

// File: hw/umi_pack.sv
//##########################################################################
// UMI response pack
// Builds an outgoing packet from command fields, addresses and data
//##########################################################################
`include "umi_macros.svh"

module umi_pack
  (
   // Command fields
   input  umi_pkg::umi_opcode_e  opcode,
   input  logic [3:0]            size,
   input  logic [19:0]           options,
   // Addresses
   input  logic [`UMI_AW-1:0]    dst_addr,
   input  logic [`UMI_AW-1:0]    src_addr,
   // Payload
   input  logic [`UMI_DW-1:0]    data,
   // Outgoing packet
   output umi_pkg::umi_packet_t  packet
   );

   import umi_pkg::*;

   umi_cmd_t cmd;                      // Assembled command word

   // Command word from its fields
   assign cmd = '{options : options,
                  size    : size,
                  opcode  : opcode};

   //#######################################################################
   // Packet assembly
   //#######################################################################

   // Field order follows umi_packet_t, cmd on top
   assign packet = '{cmd      : cmd,
                     dst_addr : dst_addr,
                     src_addr : src_addr,
                     payload  : data};

endmodule

// File: hw/umi_endpoint.sv
//##########################################################################
// UMI device endpoint
// Turns request packets into local memory accesses
// Reads come back as a registered response packet held under stall
//##########################################################################
`include "umi_macros.svh"

module umi_endpoint
  (
   input  logic                  clk,
   input  logic                  nreset,
   // Device request port
   input  logic                  req_valid,
   input  umi_pkg::umi_packet_t  req,
   output logic                  req_ready,
   // Device response port
   output logic                  resp_valid,
   output umi_pkg::umi_packet_t  resp,
   input  logic                  resp_ready,
   // Local memory port
   output mem_pkg::mem_req_t     mem_req,
   input  mem_pkg::mem_rsp_t     mem_rsp
   );

   import umi_pkg::*;

   // Unpacked request
   umi_opcode_e         req_opcode;
   logic [3:0]          req_size;
   logic [19:0]         req_options;
   logic [`UMI_AW-1:0]  req_dst_addr;
   logic [`UMI_AW-1:0]  req_src_addr;
   logic [`UMI_DW-1:0]  req_wrdata;

   // Handshake and decode
   logic                accept;
   logic                is_read;
   logic                is_write;

   // Response register without opcode
   logic [3:0]          resp_size_q;
   logic [19:0]         resp_options_q;
   logic [`UMI_AW-1:0]  resp_dst_addr_q;
   logic [`UMI_AW-1:0]  resp_src_addr_q;
   logic [`UMI_DW-1:0]  resp_data_q;

   //#######################################################################
   // Request decode
   //#######################################################################

   umi_unpack u_unpack
     (.packet   (req),
      .opcode   (req_opcode),
      .size     (req_size),
      .options  (req_options),
      .dst_addr (req_dst_addr),
      .src_addr (req_src_addr),
      .wrdata   (req_wrdata));

   assign accept   = req_valid & req_ready;
   assign is_read  = accept & (req_opcode == UMI_READ);
   assign is_write = accept & (req_opcode == UMI_WRITE);
   // Unknown opcodes accepted with neither strobe

   // Memory access strobes qualified by acceptance
   assign mem_req.addr   = req_dst_addr;
   assign mem_req.write  = is_write;   // Lands at accepting edge
   assign mem_req.read   = is_read;
   assign mem_req.size   = req_size;
   assign mem_req.wrdata = req_wrdata;

   //#######################################################################
   // Handshake
   //#######################################################################

   // Slot empty or draining this cycle
   assign req_ready = nreset & (~resp_valid | resp_ready);

   // Read wins over drain so the slot reloads in the same cycle
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         resp_valid <= 1'b0;
      else if (is_read)
         resp_valid <= 1'b1;
      else if (resp_ready)
         resp_valid <= 1'b0;

   //#######################################################################
   // Response register
   //#######################################################################

   always_ff @(posedge clk)
      if (is_read)
      begin
         resp_data_q     <= mem_rsp.rddata;
         resp_dst_addr_q <= req_src_addr;   // Back to requester
         resp_src_addr_q <= req_dst_addr;
         resp_size_q     <= req_size;
         resp_options_q  <= req_options;
      end

   umi_pack u_pack
     (.opcode   (UMI_RESP_READ),
      .size     (resp_size_q),
      .options  (resp_options_q),
      .dst_addr (resp_dst_addr_q),
      .src_addr (resp_src_addr_q),
      .data     (resp_data_q),
      .packet   (resp));

endmodule

// File: hw/umi_regmem.sv
//##########################################################################
// Local word memory
// Byte-enable writes from size and low address bits, combinational reads
//##########################################################################
`include "umi_macros.svh"

module umi_regmem
  (
   input  logic               clk,
   input  logic               nreset,
   input  mem_pkg::mem_req_t  mem_req,
   output mem_pkg::mem_rsp_t  mem_rsp
   );

   localparam int NB    = `UMI_DW / 8;              // Bytes per word
   localparam int OFS_W = $clog2(NB);               // Byte offset bits
   localparam int IDX_W = $clog2(`UMI_MEM_WORDS);   // Word index bits

   logic [`UMI_DW-1:0]  mem [`UMI_MEM_WORDS];       // Storage
   logic [IDX_W-1:0]    word_idx;
   logic [OFS_W-1:0]    byte_ofs;
   logic [NB-1:0]       be;                         // Byte enables

   // Upper address bits dropped, wraps at depth
   assign word_idx = mem_req.addr[OFS_W +: IDX_W];
   assign byte_ofs = mem_req.addr[OFS_W-1:0];

   //#######################################################################
   // Byte enables
   //#######################################################################

   always_comb
   begin
      case (mem_req.size)
         4'd0    : be = NB'(1) << byte_ofs;                    // One lane
         4'd1    : be = NB'(2'b11) << {byte_ofs[OFS_W-1:1], 1'b0};
         default : be = '1;                                    // Whole word
      endcase
   end

   //#######################################################################
   // Write port
   //#######################################################################

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         for (int i = 0; i < `UMI_MEM_WORDS; i++)
            mem[i] <= '0;
      end
      else if (mem_req.write)
      begin
         // Each lane from its own lane of wrdata
         for (int b = 0; b < NB; b++)
            if (be[b])
               mem[word_idx][8*b +: 8] <= mem_req.wrdata[8*b +: 8];
      end

   //#######################################################################
   // Read port
   //#######################################################################

   // Whole word, zero when no read strobe
   assign mem_rsp.rddata = mem_req.read ? mem[word_idx] : '0;

endmodule

// File: hw/umi_mem_top.sv
//##########################################################################
// UMI memory endpoint top
// Device port endpoint wired to the local word memory
//##########################################################################

module umi_mem_top
  (
   input  logic                  clk,
   input  logic                  nreset,
   // Device request port
   input  logic                  req_valid,
   input  umi_pkg::umi_packet_t  req,
   output logic                  req_ready,
   // Device response port
   output logic                  resp_valid,
   output umi_pkg::umi_packet_t  resp,
   input  logic                  resp_ready
   );

   mem_pkg::mem_req_t  mem_req;        // Endpoint to memory
   mem_pkg::mem_rsp_t  mem_rsp;        // Same-cycle read data

   umi_endpoint u_endpoint
     (.clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready),
      .mem_req    (mem_req),
      .mem_rsp    (mem_rsp));

   // Always ready, single cycle
   umi_regmem u_regmem
     (.clk     (clk),
      .nreset  (nreset),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp));

endmodule

// File: dv/umi_mem_checker.sv
//##########################################################################
// UMI endpoint device port checker
// Concurrent assertions on request acceptance and the response slot
//##########################################################################

module umi_mem_checker
  (
   input logic                  clk,
   input logic                  nreset,
   input logic                  req_valid,
   input umi_pkg::umi_packet_t  req,
   input logic                  req_ready,
   input logic                  resp_valid,
   input umi_pkg::umi_packet_t  resp,
   input logic                  resp_ready
   );

   import umi_pkg::*;

   // Stalled response holds
   resp_stable : assert property (@(posedge clk) disable iff (!nreset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp))
      else $error("response changed or dropped while stalled");

   resp_idle_in_reset : assert property (@(posedge clk) !nreset |-> !resp_valid)
      else $error("resp_valid high during reset");

   // Only read responses leave the endpoint
   resp_opcode : assert property (@(posedge clk) disable iff (!nreset)
      resp_valid |-> resp.cmd.opcode == UMI_RESP_READ)
      else $error("response opcode is not RESP_READ");

   read_answered : assert property (@(posedge clk) disable iff (!nreset)
      req_valid && req_ready && req.cmd.opcode == UMI_READ |=> resp_valid)
      else $error("accepted read not answered on the next cycle");

endmodule

bind umi_endpoint umi_mem_checker u_checker
  (.clk        (clk),
   .nreset     (nreset),
   .req_valid  (req_valid),
   .req        (req),
   .req_ready  (req_ready),
   .resp_valid (resp_valid),
   .resp       (resp),
   .resp_ready (resp_ready));

// File: dv/umi_mem_tb.sv
//##########################################################################
// UMI memory endpoint testbench
// Directed tests against a byte-lane memory model, with a watchdog
//##########################################################################
`include "umi_macros.svh"

module umi_mem_tb;

   import umi_pkg::*;

   localparam int NB         = `UMI_DW / 8;         // Lanes per word
   localparam int RANDOM_OPS = 200;
   localparam int NUM_OPS    = 40 + RANDOM_OPS;     // Directed plus random

   logic         clk;
   logic         nreset;
   logic         req_valid;
   umi_packet_t  req;
   logic         req_ready;
   logic         resp_valid;
   umi_packet_t  resp;
   logic         resp_ready;

   logic [7:0]   model [`UMI_MEM_WORDS][NB];        // Reference memory by lane
   int           seed   = 32'h15da_c63a;
   int           errors = 0;
   int           checks = 0;

   umi_mem_top dut
     (.clk        (clk),
      .nreset     (nreset),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .resp_valid (resp_valid),
      .resp       (resp),
      .resp_ready (resp_ready));

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   //#######################################################################
   // Reference model
   //#######################################################################

   // Word index wraps at memory depth
   function automatic int word_of(input logic [`UMI_AW-1:0] addr);
      return int'((addr >> 2) % `UMI_MEM_WORDS);
   endfunction

   function automatic void model_write(input logic [`UMI_AW-1:0] addr,
                                       input logic [3:0]         size,
                                       input logic [`UMI_DW-1:0] data);
      int lo;
      int n;
      if (size == 4'd0)
      begin
         lo = int'(addr[1:0]);                      // Single byte lane
         n  = 1;
      end
      else if (size == 4'd1)
      begin
         lo = 2 * int'(addr[1]);                    // Halfword with bit 0 ignored
         n  = 2;
      end
      else
      begin
         lo = 0;
         n  = NB;
      end
      for (int b = lo; b < lo + n; b++)
         model[word_of(addr)][b] = data[8*b +: 8];  // Lane from same lane
   endfunction

   function automatic logic [`UMI_DW-1:0] model_read(input logic [`UMI_AW-1:0] addr);
      logic [`UMI_DW-1:0] w;
      for (int b = 0; b < NB; b++)
         w[8*b +: 8] = model[word_of(addr)][b];
      return w;
   endfunction

   function automatic umi_packet_t make_packet(input logic [7:0]         op,
                                               input logic [3:0]         size,
                                               input logic [19:0]        options,
                                               input logic [`UMI_AW-1:0] dst,
                                               input logic [`UMI_AW-1:0] src,
                                               input logic [`UMI_DW-1:0] data);
      umi_packet_t p;
      p.cmd.opcode  = umi_opcode_e'(op);            // May be an unknown code
      p.cmd.size    = size;
      p.cmd.options = options;
      p.dst_addr    = dst;
      p.src_addr    = src;
      p.payload     = data;
      return p;
   endfunction

   //#######################################################################
   // Checks and bus helpers
   //#######################################################################

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   task automatic check_packet(input umi_packet_t exp);
      check_field("resp.cmd.opcode", 32'(resp.cmd.opcode), 32'(exp.cmd.opcode));
      check_field("resp.cmd.size", 32'(resp.cmd.size), 32'(exp.cmd.size));
      check_field("resp.cmd.options", 32'(resp.cmd.options), 32'(exp.cmd.options));
      check_field("resp.dst_addr", resp.dst_addr, exp.dst_addr);
      check_field("resp.src_addr", resp.src_addr, exp.src_addr);
      check_field("resp.payload", resp.payload, exp.payload);
   endtask

   // Starts and ends one time unit after a rising edge
   task automatic send_request(input umi_packet_t pkt);
      int waited;
      waited    = 0;
      req_valid = 1'b1;
      req       = pkt;
      @(negedge clk);
      while (!req_ready && waited < 20)
      begin
         waited++;
         @(negedge clk);
      end
      assert (req_ready)
      else
         report_error("request not accepted within 20 cycles");
      @(posedge clk);                               // Accepting edge
      #1;
      req_valid = 1'b0;
   endtask

   task automatic expect_response(input umi_packet_t exp, input int stall);
      umi_packet_t held;
      int          waited;
      waited     = 0;
      resp_ready = (stall == 0);
      @(negedge clk);
      while (!resp_valid && waited < 8)
      begin
         waited++;
         @(negedge clk);
      end
      assert (resp_valid)
      else
         report_error("no response within 8 cycles of a read");
      check_packet(exp);
      held = resp;
      repeat (stall)                                // Held and blocking
      begin
         @(negedge clk);
         check_field("resp_valid", 32'(resp_valid), 32'd1);
         check_field("req_ready", 32'(req_ready), 32'd0);
         assert (resp === held)
         else
            report_error("response changed while stalled");
      end
      if (stall > 0)
      begin
         @(posedge clk);
         #1;
         resp_ready = 1'b1;
      end
      @(posedge clk);                               // Response taken
      #1;
   endtask

   task automatic expect_no_response(input int cycles);
      repeat (cycles)
      begin
         @(negedge clk);
         assert (!resp_valid)
         else
            report_error("response seen where none was expected");
      end
      @(posedge clk);
      #1;
   endtask

   task automatic do_write(input logic [`UMI_AW-1:0] addr, input logic [3:0] size,
                           input logic [`UMI_DW-1:0] data);
      send_request(make_packet(UMI_WRITE, size, 20'h0, addr, 32'h0, data));
      model_write(addr, size, data);
   endtask

   task automatic do_read(input logic [`UMI_AW-1:0] addr, input logic [3:0] size,
                          input logic [19:0] options, input logic [`UMI_AW-1:0] src,
                          input int stall);
      send_request(make_packet(UMI_READ, size, options, addr, src, 32'h0));
      // Addresses swap on the way back
      expect_response(make_packet(UMI_RESP_READ, size, options, src, addr,
                                  model_read(addr)), stall);
   endtask

   //#######################################################################
   // Directed tests
   //#######################################################################

   task automatic test_word_rw();
      logic [`UMI_AW-1:0] addrs [4];
      addrs = '{32'h0000_0000, 32'h0000_0004, 32'h0000_03fc, 32'h1234_0010};
      do_read(32'h0000_0040, 4'd2, 20'h0, 32'h0, 0);   // Untouched word reads 0
      foreach (addrs[i])
         do_write(addrs[i], 4'd2, $random(seed));
      foreach (addrs[i])
         do_read(addrs[i], 4'd2, 20'h0, 32'h0, 0);
   endtask

   task automatic test_subword();
      logic [`UMI_AW-1:0] base;
      base = 32'h0000_0080;
      do_write(base, 4'd2, 32'haabb_ccdd);
      for (int lane = 0; lane < NB; lane++)
      begin
         do_write(base + lane, 4'd0, $random(seed));   // Other lanes are noise
         do_read(base, 4'd2, 20'h0, 32'h0, 0);
      end
      for (int ofs = 0; ofs < NB; ofs++)
      begin
         do_write(base + ofs, 4'd1, $random(seed));
         do_read(base, 4'd2, 20'h0, 32'h0, 0);
      end
   endtask

   task automatic test_backpressure();
      umi_packet_t first;
      do_write(32'h0000_0100, 4'd2, 32'h1111_2222);
      do_write(32'h0000_0104, 4'd2, 32'h3333_4444);
      first = make_packet(UMI_RESP_READ, 4'd2, 20'h0000a, 32'h0, 32'h0000_0100,
                          model_read(32'h0000_0100));
      send_request(make_packet(UMI_READ, 4'd2, 20'h0000a, 32'h0000_0100, 32'h0, 32'h0));
      // Stall with a second read queued behind
      resp_ready = 1'b0;
      req_valid  = 1'b1;
      req        = make_packet(UMI_READ, 4'd2, 20'h0000b, 32'h0000_0104, 32'h0, 32'h0);
      repeat (5)
      begin
         @(negedge clk);
         check_field("resp_valid", 32'(resp_valid), 32'd1);
         check_field("req_ready", 32'(req_ready), 32'd0);
         check_packet(first);
         @(posedge clk);
         #1;
      end
      resp_ready = 1'b1;
      @(negedge clk);
      check_field("req_ready", 32'(req_ready), 32'd1);  // Drain frees slot
      @(posedge clk);                                   // First out and second in
      #1;
      req_valid = 1'b0;
      expect_response(make_packet(UMI_RESP_READ, 4'd2, 20'h0000b, 32'h0, 32'h0000_0104,
                                  model_read(32'h0000_0104)), 0);
   endtask

   task automatic test_header_echo();
      do_write(32'h0000_0200, 4'd2, 32'hcafe_f00d);
      do_read(32'h0000_0200, 4'd0, 20'habcde, 32'h8000_1000, 0);
      do_read(32'h0000_0202, 4'd1, 20'h12345, 32'h0000_0ff0, 1);
      do_read(32'hffff_0200, 4'd2, 20'hfffff, 32'h5555_aaaa, 2);  // Wrapped address
   endtask

   task automatic test_unknown_op();
      do_write(32'h0000_0300, 4'd2, 32'h0bad_beef);
      send_request(make_packet(8'h7f, 4'd2, 20'h0, 32'h0000_0300, 32'h0, 32'hdead_0000));
      expect_no_response(4);
      do_read(32'h0000_0300, 4'd2, 20'h0, 32'h0, 0);   // Model untouched
   endtask

   task automatic test_random();
      logic [`UMI_AW-1:0] addr;
      logic [3:0]         size;
      int                 stall;
      repeat (RANDOM_OPS)
      begin
         addr  = $random(seed) & 32'hfff0_003f;        // 16 words with wrapping high bits
         size  = 4'({$random(seed)} % 3);
         stall = ({$random(seed)} % 2 == 0) ? int'({$random(seed)} % 4) : 0;
         if ($random(seed) & 1)
            do_write(addr, size, $random(seed));
         else
            do_read(addr, size, 20'($random(seed)), $random(seed), stall);
      end
   endtask

   //#######################################################################
   // Sequence and watchdog
   //#######################################################################

   initial
   begin
      nreset     = 1'b0;
      req_valid  = 1'b0;
      req        = '0;
      resp_ready = 1'b1;
      foreach (model[w, b])
         model[w][b] = 8'h00;
      repeat (8) @(posedge clk);
      #1;
      check_field("resp_valid", 32'(resp_valid), 32'd0);  // Both low in reset
      check_field("req_ready", 32'(req_ready), 32'd0);
      nreset = 1'b1;
      @(negedge clk);
      check_field("req_ready", 32'(req_ready), 32'd1);    // Ready as soon as reset lifts
      @(posedge clk);
      #1;
      test_word_rw();
      test_subword();
      test_backpressure();
      test_header_echo();
      test_unknown_op();
      test_random();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   initial
   begin
      #(NUM_OPS * 20 + 1000);
      $display("Watchdog expired before the tests completed");
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: umi_mem_top.f
+incdir+hw
hw/umi_pkg.sv
hw/mem_pkg.sv
hw/umi_unpack.sv
hw/umi_pack.sv
hw/umi_endpoint.sv
hw/umi_regmem.sv
hw/umi_mem_top.sv
dv/umi_mem_checker.sv
dv/umi_mem_tb.sv

// File: Makefile
# Verilator build and run for the UMI memory endpoint

VERILATOR ?= verilator
TOP       ?= umi_mem_tb
FLIST     ?= umi_mem_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard hw/*.svh)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
